// ==== design/pkt_app_params.svh ====
`ifndef PKT_APP_PARAMS_SVH
`define PKT_APP_PARAMS_SVH

// ====================
// Steering lanes
// ====================

// Identical lanes behind the dispatcher
`define PKT_APP_NUM_LANES 4
// Words buffered per lane ahead of the output stage
`define PKT_APP_LANE_DEPTH 2
// Host output buffer
`define PKT_APP_HOST_DEPTH 4

// ====================
// Field widths
// ====================
`define PKT_APP_DATA_W 32
`define PKT_APP_TS_W 32

// Egress port number that selects the host output
`define PKT_APP_HOST_PORT 3

`endif

// ==== design/pkt_app_pkg.sv ====
`include "pkt_app_params.svh"
`default_nettype none

package pkt_app_pkg;

    // Ingress and egress port number
    typedef logic [1:0] port_t;

    // Word on the input, inside the lanes and on the switch output
    typedef struct packed {
        logic [`PKT_APP_DATA_W-1:0] data;
        port_t                      tid;
        port_t                      tdest;
    } pkt_t;

    // Word on the host output, tdest replaced by the lane timestamp
    typedef struct packed {
        logic [`PKT_APP_DATA_W-1:0] data;
        port_t                      tid;
        logic [`PKT_APP_TS_W-1:0]   timestamp;
    } host_pkt_t;

    // One egress entry per ingress port
    typedef port_t [2**$bits(port_t)-1:0] dest_map_t;

    // Management write request
    typedef struct packed {
        port_t addr;
        port_t dest;
    } map_wr_t;

endpackage

`default_nettype wire

// ==== design/stream_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module stream_fifo #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 2
) (
    input  logic  axil_if,
    input  logic  reset,
    input  item_t in_item,
    input  logic  in_valid,
    output logic  in_ready,
    output item_t out_item,
    output logic  out_valid,
    input  logic  out_ready
);

    localparam int ptr_w = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int cnt_w = $clog2(DEPTH + 1);

    item_t mem [DEPTH];

    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    logic push;
    logic pop;

    // No pass-through when full, so in_ready never waits on out_ready
    assign in_ready  = (count != cnt_w'(DEPTH));
    assign out_valid = (count != '0);
    assign out_item  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge axil_if) begin
        if (push) begin
            mem[wr_ptr] <= in_item;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge axil_if) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_w'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/dest_map_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pkt_app_params.svh"

module dest_map_regs
    import pkt_app_pkg::*;
(
    input  logic      axil_if,
    input  logic      reset,
    input  logic      map_req,
    input  map_wr_t   map_wr,
    output logic      map_ack,
    output dest_map_t dest_map
);

    localparam int num_entries = 2**$bits(port_t);

    // ====================
    // Four-phase handshake
    // ====================

    // Entry is written on the same edge that raises the ack
    logic wr_en;

    assign wr_en = map_req && !map_ack;

    always_ff @(posedge axil_if) begin
        if (reset) begin
            map_ack <= 1'b0;
        end else if (wr_en) begin
            map_ack <= 1'b1;
        end else if (!map_req) begin
            map_ack <= 1'b0;
        end
    end

    // ====================
    // Table
    // ====================

    // Identity map after reset, port i goes to port i
    always_ff @(posedge axil_if) begin
        if (reset) begin
            for (int i = 0; i < num_entries; i++) begin
                dest_map[i] <= port_t'(i);
            end
        end else if (wr_en) begin
            dest_map[map_wr.addr] <= map_wr.dest;
        end
    end

endmodule

`default_nettype wire

// ==== design/lane_dispatch.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pkt_app_params.svh"

module lane_dispatch
    import pkt_app_pkg::*;
(
    input  logic                          axil_if,
    input  logic                          reset,
    input  pkt_t                          in_pkt,
    input  logic                          in_valid,
    output logic                          in_ready,
    output pkt_t                          lane_pkt [`PKT_APP_NUM_LANES],
    output logic [`PKT_APP_NUM_LANES-1:0] lane_valid,
    input  logic [`PKT_APP_NUM_LANES-1:0] lane_ready
);

    localparam int lane_w = $clog2(`PKT_APP_NUM_LANES);

    logic [lane_w-1:0] lane_sel;
    logic              run;

    // Held off until the first edge out of reset
    always_ff @(posedge axil_if) begin
        if (reset) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // Payload fans out to all lanes, only the selected lane sees valid
    always_comb begin
        for (int i = 0; i < `PKT_APP_NUM_LANES; i++) begin
            lane_pkt[i]   = in_pkt;
            lane_valid[i] = run && in_valid && (lane_sel == lane_w'(i));
        end
    end

    assign in_ready = run && lane_ready[lane_sel];

    // Round-robin pointer moves on each completed transfer
    always_ff @(posedge axil_if) begin
        if (reset) begin
            lane_sel <= '0;
        end else if (in_valid && in_ready) begin
            if (lane_sel == lane_w'(`PKT_APP_NUM_LANES - 1)) begin
                lane_sel <= '0;
            end else begin
                lane_sel <= lane_sel + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/steer_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pkt_app_params.svh"

module steer_lane
    import pkt_app_pkg::*;
(
    input  logic                     axil_if,
    input  logic                     reset,
    input  logic [`PKT_APP_TS_W-1:0] timestamp,
    input  dest_map_t                dest_map,
    input  pkt_t                     in_pkt,
    input  logic                     in_valid,
    output logic                     in_ready,
    output pkt_t                     out_pkt,
    output logic [`PKT_APP_TS_W-1:0] out_ts,
    output logic                     out_valid,
    input  logic                     out_ready
);

    pkt_t fifo_pkt;
    logic fifo_valid;
    logic fifo_ready;
    pkt_t steered_pkt;
    logic load;

    // ====================
    // Lane buffer
    // ====================
    stream_fifo #(
        .item_t (pkt_t),
        .DEPTH  (`PKT_APP_LANE_DEPTH)
    ) i_lane_fifo (
        .axil_if   (axil_if),
        .reset     (reset),
        .in_item   (in_pkt),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_item  (fifo_pkt),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready)
    );

    // ====================
    // Lookup and stamp
    // ====================

    // Table entry for the ingress port replaces tdest
    always_comb begin
        steered_pkt       = fifo_pkt;
        steered_pkt.tdest = dest_map[fifo_pkt.tid];
    end

    // Output stage refills when empty or draining
    assign fifo_ready = !out_valid || out_ready;
    assign load       = fifo_valid && fifo_ready;

    always_ff @(posedge axil_if) begin
        if (load) begin
            out_pkt <= steered_pkt;
            out_ts  <= timestamp;
        end
    end

    always_ff @(posedge axil_if) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (fifo_ready) begin
            out_valid <= fifo_valid;
        end
    end

endmodule

`default_nettype wire

// ==== design/lane_collect.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pkt_app_params.svh"

module lane_collect
    import pkt_app_pkg::*;
(
    input  logic                          axil_if,
    input  logic                          reset,
    input  pkt_t                          lane_pkt [`PKT_APP_NUM_LANES],
    input  logic [`PKT_APP_TS_W-1:0]      lane_ts [`PKT_APP_NUM_LANES],
    input  logic [`PKT_APP_NUM_LANES-1:0] lane_valid,
    output logic [`PKT_APP_NUM_LANES-1:0] lane_ready,
    output pkt_t                          sw_pkt,
    output logic                          sw_valid,
    input  logic                          sw_ready,
    output host_pkt_t                     host_pkt,
    output logic                          host_valid,
    input  logic                          host_ready
);

    localparam int lane_w = $clog2(`PKT_APP_NUM_LANES);

    logic [lane_w-1:0] lane_sel;
    pkt_t              cur_pkt;
    logic              cur_valid;
    logic              cur_is_host;
    logic              take;

    host_pkt_t         stage_pkt;
    logic              stage_valid;
    logic              stage_ready;
    logic              stage_free;
    logic              sw_free;

    assign cur_pkt     = lane_pkt[lane_sel];
    assign cur_valid   = lane_valid[lane_sel];
    assign cur_is_host = (cur_pkt.tdest == port_t'(`PKT_APP_HOST_PORT));

    assign sw_free    = !sw_valid || sw_ready;
    assign stage_free = !stage_valid || stage_ready;

    // Stall on the selected lane until its destination has room
    assign take = cur_valid && (cur_is_host ? stage_free : sw_free);

    always_comb begin
        for (int i = 0; i < `PKT_APP_NUM_LANES; i++) begin
            lane_ready[i] = take && (lane_sel == lane_w'(i));
        end
    end

    // Same round-robin order as the dispatcher keeps global order
    always_ff @(posedge axil_if) begin
        if (reset) begin
            lane_sel <= '0;
        end else if (take) begin
            if (lane_sel == lane_w'(`PKT_APP_NUM_LANES - 1)) begin
                lane_sel <= '0;
            end else begin
                lane_sel <= lane_sel + 1'b1;
            end
        end
    end

    // ====================
    // Switch output
    // ====================
    always_ff @(posedge axil_if) begin
        if (take && !cur_is_host) begin
            sw_pkt <= cur_pkt;
        end
    end

    always_ff @(posedge axil_if) begin
        if (reset) begin
            sw_valid <= 1'b0;
        end else if (take && !cur_is_host) begin
            sw_valid <= 1'b1;
        end else if (sw_ready) begin
            sw_valid <= 1'b0;
        end
    end

    // ====================
    // Host output
    // ====================

    // Staging register rebuilds the word with the lane timestamp
    always_ff @(posedge axil_if) begin
        if (take && cur_is_host) begin
            stage_pkt.data      <= cur_pkt.data;
            stage_pkt.tid       <= cur_pkt.tid;
            stage_pkt.timestamp <= lane_ts[lane_sel];
        end
    end

    always_ff @(posedge axil_if) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (take && cur_is_host) begin
            stage_valid <= 1'b1;
        end else if (stage_ready) begin
            stage_valid <= 1'b0;
        end
    end

    stream_fifo #(
        .item_t (host_pkt_t),
        .DEPTH  (`PKT_APP_HOST_DEPTH)
    ) i_host_fifo (
        .axil_if   (axil_if),
        .reset     (reset),
        .in_item   (stage_pkt),
        .in_valid  (stage_valid),
        .in_ready  (stage_ready),
        .out_item  (host_pkt),
        .out_valid (host_valid),
        .out_ready (host_ready)
    );

endmodule

`default_nettype wire

// ==== design/pkt_steer_app.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pkt_app_params.svh"

module pkt_steer_app
    import pkt_app_pkg::*;
(
    input  logic                     axil_if,
    input  logic                     reset,
    input  logic [`PKT_APP_TS_W-1:0] timestamp,
    input  logic                     map_req,
    input  map_wr_t                  map_wr,
    output logic                     map_ack,
    input  pkt_t                     in_pkt,
    input  logic                     in_valid,
    output logic                     in_ready,
    output pkt_t                     sw_pkt,
    output logic                     sw_valid,
    input  logic                     sw_ready,
    output host_pkt_t                host_pkt,
    output logic                     host_valid,
    input  logic                     host_ready
);

    dest_map_t                     dest_map;

    // Dispatcher to lanes
    pkt_t                          disp_pkt [`PKT_APP_NUM_LANES];
    logic [`PKT_APP_NUM_LANES-1:0] disp_valid;
    logic [`PKT_APP_NUM_LANES-1:0] disp_ready;

    // Lanes to collector
    pkt_t                          lane_pkt [`PKT_APP_NUM_LANES];
    logic [`PKT_APP_TS_W-1:0]      lane_ts [`PKT_APP_NUM_LANES];
    logic [`PKT_APP_NUM_LANES-1:0] lane_valid;
    logic [`PKT_APP_NUM_LANES-1:0] lane_ready;

    dest_map_regs i_dest_map_regs (
        .axil_if  (axil_if),
        .reset    (reset),
        .map_req  (map_req),
        .map_wr   (map_wr),
        .map_ack  (map_ack),
        .dest_map (dest_map)
    );

    lane_dispatch i_lane_dispatch (
        .axil_if    (axil_if),
        .reset      (reset),
        .in_pkt     (in_pkt),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lane_pkt   (disp_pkt),
        .lane_valid (disp_valid),
        .lane_ready (disp_ready)
    );

    // ====================
    // Steering lanes
    // ====================
    for (genvar g = 0; g < `PKT_APP_NUM_LANES; g++) begin : g_lane
        steer_lane i_steer_lane (
            .axil_if   (axil_if),
            .reset     (reset),
            .timestamp (timestamp),
            .dest_map  (dest_map),
            .in_pkt    (disp_pkt[g]),
            .in_valid  (disp_valid[g]),
            .in_ready  (disp_ready[g]),
            .out_pkt   (lane_pkt[g]),
            .out_ts    (lane_ts[g]),
            .out_valid (lane_valid[g]),
            .out_ready (lane_ready[g])
        );
    end

    lane_collect i_lane_collect (
        .axil_if    (axil_if),
        .reset      (reset),
        .lane_pkt   (lane_pkt),
        .lane_ts    (lane_ts),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready),
        .sw_pkt     (sw_pkt),
        .sw_valid   (sw_valid),
        .sw_ready   (sw_ready),
        .host_pkt   (host_pkt),
        .host_valid (host_valid),
        .host_ready (host_ready)
    );

endmodule

`default_nettype wire

// ==== tb/pkt_steer_app_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module pkt_steer_app_checker
    import pkt_app_pkg::*;
(
    input logic      axil_if,
    input logic      reset,
    input logic      map_req,
    input logic      map_ack,
    input logic      in_ready,
    input pkt_t      sw_pkt,
    input logic      sw_valid,
    input logic      sw_ready,
    input host_pkt_t host_pkt,
    input logic      host_valid,
    input logic      host_ready
);

    int   error_count = 0;
    logic reset_d;

    // Reset seen on two edges means all registers are cleared
    always_ff @(posedge axil_if) begin
        reset_d <= reset;
    end

    // ====================
    // Stream outputs
    // ====================
    sw_hold: assert property (@(posedge axil_if) disable iff (reset)
        sw_valid && !sw_ready |=> sw_valid && $stable(sw_pkt))
        else begin
            $error("Switch output dropped valid or changed its word before ready");
            error_count++;
        end

    host_hold: assert property (@(posedge axil_if) disable iff (reset)
        host_valid && !host_ready |=> host_valid && $stable(host_pkt))
        else begin
            $error("Host output dropped valid or changed its word before ready");
            error_count++;
        end

    // ====================
    // Management and reset
    // ====================
    ack_needs_req: assert property (@(posedge axil_if) disable iff (reset)
        $rose(map_ack) |-> $past(map_req))
        else begin
            $error("map_ack rose without a pending map_req");
            error_count++;
        end

    quiet_in_reset: assert property (@(posedge axil_if)
        reset && reset_d |-> !sw_valid && !host_valid && !in_ready && !map_ack)
        else begin
            $error("Handshake output active during reset");
            error_count++;
        end

endmodule

`default_nettype wire

// ==== tb/tb_pkt_steer_app.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "pkt_app_params.svh"

module tb_pkt_steer_app
    import pkt_app_pkg::*;
();

    // Stimulus kinds
    localparam logic [1:0] k_pkt   = 2'd0;
    localparam logic [1:0] k_map   = 2'd1;
    localparam logic [1:0] k_burst = 2'd2;
    localparam logic [1:0] k_fill  = 2'd3;

    // Output ready patterns
    localparam logic [1:0] ready_on   = 2'd0;
    localparam logic [1:0] ready_rand = 2'd1;
    localparam logic [1:0] ready_off  = 2'd2;

    localparam int num_stim     = 18;
    localparam int cycle_limit  = 20 * num_stim + 200;
    localparam int fill_max     = 40;
    localparam int stall_cycles = 10;

    typedef struct packed {
        logic [1:0]                 kind;
        port_t                      addr;
        logic [`PKT_APP_DATA_W-1:0] value;
        logic [1:0]                 sw_mode;
        logic [1:0]                 host_mode;
    } stim_t;

    typedef struct packed {
        logic [`PKT_APP_DATA_W-1:0] data;
        port_t                      tid;
        logic [`PKT_APP_TS_W-1:0]   ts_min;
    } host_exp_t;

    logic                     axil_if;
    logic                     reset;
    logic [`PKT_APP_TS_W-1:0] timestamp  = '0;
    logic                     map_req;
    map_wr_t                  map_wr;
    logic                     map_ack;
    pkt_t                     in_pkt;
    logic                     in_valid;
    logic                     in_ready;
    pkt_t                     sw_pkt;
    logic                     sw_valid;
    logic                     sw_ready   = 1'b0;
    host_pkt_t                host_pkt;
    logic                     host_valid;
    logic                     host_ready = 1'b0;

    stim_t       stim_table [num_stim];
    port_t       ref_map [4];
    pkt_t        sw_q [$];
    host_exp_t   host_q [$];
    logic [16:0] ready_lfsr = 17'd89629;
    logic [16:0] tid_lfsr   = 17'd89629;
    logic [1:0]  sw_mode;
    logic [1:0]  host_mode;
    logic        stall_seen;
    int          cycle      = 0;
    int          data_seq;

    pkt_steer_app i_pkt_steer_app (
        .axil_if    (axil_if),
        .reset      (reset),
        .timestamp  (timestamp),
        .map_req    (map_req),
        .map_wr     (map_wr),
        .map_ack    (map_ack),
        .in_pkt     (in_pkt),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .sw_pkt     (sw_pkt),
        .sw_valid   (sw_valid),
        .sw_ready   (sw_ready),
        .host_pkt   (host_pkt),
        .host_valid (host_valid),
        .host_ready (host_ready)
    );

    bind pkt_steer_app pkt_steer_app_checker i_pkt_steer_app_checker (
        .axil_if    (axil_if),
        .reset      (reset),
        .map_req    (map_req),
        .map_ack    (map_ack),
        .in_ready   (in_ready),
        .sw_pkt     (sw_pkt),
        .sw_valid   (sw_valid),
        .sw_ready   (sw_ready),
        .host_pkt   (host_pkt),
        .host_valid (host_valid),
        .host_ready (host_ready)
    );

    always #4 axil_if = ~axil_if;

    // ====================
    // Helpers
    // ====================

    // Fibonacci LFSR x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    function automatic stim_t make_entry(input logic [1:0] kind, input port_t addr,
                                         input logic [`PKT_APP_DATA_W-1:0] value,
                                         input logic [1:0] sw_mode_in,
                                         input logic [1:0] host_mode_in);
        stim_t e;
        e.kind      = kind;
        e.addr      = addr;
        e.value     = value;
        e.sw_mode   = sw_mode_in;
        e.host_mode = host_mode_in;
        return e;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic random_tid(output port_t tid);
        tid_lfsr = lfsr_next(tid_lfsr);
        tid[0]   = tid_lfsr[0];
        tid_lfsr = lfsr_next(tid_lfsr);
        tid[1]   = tid_lfsr[0];
    endtask

    task automatic check_switch_word;
        pkt_t exp;
        assert (sw_q.size() != 0)
            else report_failure("Switch output delivered a word that was never sent");
        exp = sw_q.pop_front();
        assert (sw_pkt == exp) else report_failure($sformatf(
            "ERROR at %0t: sw_pkt got %h expected %h", $time, sw_pkt, exp));
    endtask

    task automatic check_host_word;
        host_exp_t exp;
        assert (host_q.size() != 0)
            else report_failure("Host output delivered a word that was never sent");
        exp = host_q.pop_front();
        assert (host_pkt.data == exp.data && host_pkt.tid == exp.tid)
            else report_failure($sformatf(
                "ERROR at %0t: host_pkt data/tid got %h/%0d expected %h/%0d",
                $time, host_pkt.data, host_pkt.tid, exp.data, exp.tid));
        // Stamp lies between input and output transfer
        assert (host_pkt.timestamp >= exp.ts_min && host_pkt.timestamp <= timestamp)
            else report_failure($sformatf(
                "ERROR at %0t: host_pkt.timestamp got %0d expected %0d to %0d",
                $time, host_pkt.timestamp, exp.ts_min, timestamp));
    endtask

    // Ready, timestamp and output checks once per cycle
    always @(negedge axil_if) begin
        cycle      = cycle + 1;
        timestamp  = cycle;
        ready_lfsr = lfsr_next(ready_lfsr);
        sw_ready   = (sw_mode == ready_rand) ? ready_lfsr[0] : (sw_mode == ready_on);
        ready_lfsr = lfsr_next(ready_lfsr);
        host_ready = (host_mode == ready_rand) ? ready_lfsr[0] : (host_mode == ready_on);
        #1;
        if (!reset && sw_valid && sw_ready) begin
            check_switch_word();
        end
        if (!reset && host_valid && host_ready) begin
            check_host_word();
        end
        assert (i_pkt_steer_app.i_pkt_steer_app_checker.error_count == 0)
            else report_failure("Bound checker flagged a handshake violation");
        assert (cycle < cycle_limit) else report_failure($sformatf(
            "Timeout after %0d cycles with the run still going", cycle));
    end

    // ====================
    // Stimulus tasks
    // ====================

    task automatic send_word(input port_t tid, input logic [`PKT_APP_DATA_W-1:0] data);
        pkt_t      word;
        pkt_t      sexp;
        host_exp_t hexp;
        int        blocked;
        logic      accepted;
        word.data  = data;
        word.tid   = tid;
        word.tdest = '0;
        blocked    = 0;
        accepted   = 1'b0;
        @(negedge axil_if);
        in_pkt   = word;
        in_valid = 1'b1;
        while (!accepted) begin
            #1;
            if (in_ready) begin
                if (ref_map[tid] == port_t'(`PKT_APP_HOST_PORT)) begin
                    hexp.data   = data;
                    hexp.tid    = tid;
                    hexp.ts_min = timestamp;
                    host_q.push_back(hexp);
                end else begin
                    sexp       = word;
                    sexp.tdest = ref_map[tid];
                    sw_q.push_back(sexp);
                end
                accepted = 1'b1;
                @(posedge axil_if);
            end else begin
                blocked++;
                // Input stalled behind held outputs, so let them drain
                if (blocked == stall_cycles && sw_mode == ready_off && host_mode == ready_off) begin
                    stall_seen = 1'b1;
                    sw_mode    = ready_rand;
                    host_mode  = ready_rand;
                end
                @(negedge axil_if);
            end
        end
    endtask

    task automatic wait_drain;
        @(negedge axil_if);
        in_valid = 1'b0;
        while (sw_q.size() != 0 || host_q.size() != 0) begin
            @(negedge axil_if);
        end
    endtask

    // Lanes look up at their output stage, so the pipeline is emptied first
    task automatic write_map(input port_t addr, input port_t dest);
        wait_drain();
        @(negedge axil_if);
        in_valid = 1'b0;
        assert (!map_ack) else report_failure("map_ack was high before a new request");
        map_wr.addr = addr;
        map_wr.dest = dest;
        map_req     = 1'b1;
        @(negedge axil_if);
        assert (map_ack) else report_failure("map_ack did not rise one cycle after map_req");
        ref_map[addr] = dest;
        map_req       = 1'b0;
        @(negedge axil_if);
        #1;
        assert (!map_ack) else report_failure("map_ack did not fall after map_req was lowered");
    endtask

    task automatic fill_until_blocked;
        int    offered;
        port_t tid;
        offered    = 0;
        stall_seen = 1'b0;
        while (!stall_seen) begin
            assert (offered < fill_max)
                else report_failure("in_ready stayed high with both outputs held not ready");
            random_tid(tid);
            send_word(tid, 32'hC000_0000 + 32'(data_seq));
            data_seq++;
            offered++;
        end
    endtask

    task automatic apply_entry(input stim_t e);
        port_t tid;
        sw_mode   = e.sw_mode;
        host_mode = e.host_mode;
        case (e.kind)
            k_map: write_map(e.addr, e.value[1:0]);
            k_pkt: send_word(e.addr, e.value);
            k_burst: begin
                for (int n = 0; n < int'(e.value); n++) begin
                    random_tid(tid);
                    send_word(tid, 32'hB000_0000 + 32'(data_seq));
                    data_seq++;
                end
            end
            default: fill_until_blocked();
        endcase
    endtask

    // ====================
    // Main sequence
    // ====================
    initial begin
        axil_if   = 1'b0;
        reset     = 1'b1;
        map_req   = 1'b0;
        map_wr    = '0;
        in_pkt    = '0;
        in_valid  = 1'b0;
        sw_mode   = ready_on;
        host_mode = ready_on;
        data_seq  = 0;
        for (int i = 0; i < 4; i++) begin
            ref_map[i] = port_t'(i);
        end

        // Identity map first, then remapped ports
        stim_table[0]  = make_entry(k_pkt, 2'd0, 32'h1000_0000, ready_on, ready_on);
        stim_table[1]  = make_entry(k_pkt, 2'd1, 32'h1000_0001, ready_on, ready_on);
        stim_table[2]  = make_entry(k_pkt, 2'd2, 32'h1000_0002, ready_on, ready_on);
        stim_table[3]  = make_entry(k_pkt, 2'd3, 32'h1000_0003, ready_on, ready_on);
        stim_table[4]  = make_entry(k_pkt, 2'd2, 32'h1000_0004, ready_on, ready_on);
        stim_table[5]  = make_entry(k_pkt, 2'd3, 32'h1000_0005, ready_on, ready_on);
        stim_table[6]  = make_entry(k_map, 2'd0, 32'd3, ready_on, ready_on);
        stim_table[7]  = make_entry(k_map, 2'd2, 32'd1, ready_on, ready_on);
        stim_table[8]  = make_entry(k_pkt, 2'd0, 32'h2000_0000, ready_on, ready_on);
        stim_table[9]  = make_entry(k_pkt, 2'd2, 32'h2000_0001, ready_on, ready_on);
        stim_table[10] = make_entry(k_pkt, 2'd1, 32'h2000_0002, ready_on, ready_on);
        stim_table[11] = make_entry(k_pkt, 2'd3, 32'h2000_0003, ready_on, ready_on);
        stim_table[12] = make_entry(k_burst, 2'd0, 32'd32, ready_rand, ready_rand);
        stim_table[13] = make_entry(k_map, 2'd3, 32'd0, ready_on, ready_on);
        stim_table[14] = make_entry(k_burst, 2'd0, 32'd24, ready_rand, ready_rand);
        stim_table[15] = make_entry(k_fill, 2'd0, 32'd0, ready_off, ready_off);
        stim_table[16] = make_entry(k_burst, 2'd0, 32'd12, ready_on, ready_rand);
        stim_table[17] = make_entry(k_map, 2'd0, 32'd0, ready_on, ready_on);

        repeat (2) @(posedge axil_if);
        @(negedge axil_if);
        reset = 1'b0;

        for (int idx = 0; idx < num_stim; idx++) begin
            apply_entry(stim_table[idx]);
        end

        wait_drain();
        repeat (4) @(negedge axil_if);
        // Lanes and outputs empty again, so the input accepts and nothing is pending
        assert (!sw_valid && !host_valid && in_ready)
            else report_failure("DUT did not return to idle after all words were delivered");
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== pkt_steer_app.f ====
+incdir+design
design/pkt_app_pkg.sv
design/stream_fifo.sv
design/dest_map_regs.sv
design/lane_dispatch.sv
design/steer_lane.sv
design/lane_collect.sv
design/pkt_steer_app.sv
tb/pkt_steer_app_checker.sv
tb/tb_pkt_steer_app.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f pkt_steer_app.f \
    --top-module tb_pkt_steer_app &&
sim_out="$(./obj_dir/Vtb_pkt_steer_app)" ;
printf '%s\n' "$sim_out" ;
printf '%s\n' "$sim_out" | grep -qx "NO ERRORS" &&
echo "Simulation passed" || { echo "Simulation failed" ; exit 1 ; }
